/* project.f */
+incdir+verilog
+incdir+tb
verilog/vdec_pkg.sv
verilog/apu_issue_ctrl.sv
verilog/vop_decode.sv
verilog/vreg_sequencer.sv
verilog/vector_decoder_top.sv
tb/tb_vector_decoder.sv

/* run_sim.sh */
#!/bin/sh
# build the vector decoder testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f project.f --top-module tb_vector_decoder -o sim_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Checks failed" sim.log; then
    exit 1
fi
exit 0

/* tb/vdec_model.svh */
// reference model of the decode table and beat rules, included inside the testbench module body
`ifndef VDEC_MODEL_SVH
`define VDEC_MODEL_SVH

// expected controls of one executing cycle
typedef struct packed {
    pe_ctrl_t   pe;
    vec_ctrl_t  vc;
    vlsu_ctrl_t ls;
    logic       multi;
    logic       fixed;
    logic       accum;
} model_ctrl_t;

function automatic pe_ctrl_t pe_of(pe_arith_op_e op, pe_saturate_mode_e sat,
    pe_output_mode_e mode, pe_operand_e opnd, logic [1:0] wide);
    return {op, sat, mode, opnd, wide};
endfunction

function automatic model_ctrl_t model_decode(instr_word_u w);
    model_ctrl_t m;
    pe_operand_e vx;
    pe_operand_e vxi;
    logic        red;
    m   = '0;
    red = 1'b0;
    vx  = (w.opv.funct3 == V_OPIVX) ? PE_OPERAND_SCALAR : PE_OPERAND_VS1;
    vxi = (w.opv.funct3 == V_OPIVI) ? PE_OPERAND_IMMEDIATE : vx;
    if (w.opv.opcode == V_MAJOR_LOAD_FP && w.opv.funct3 == V_MEM_WIDTH)
    begin
        // en, load, store, strided
        m.ls        = {1'b1, 1'b1, 1'b0, |w.opv.funct6[2:0]};
        m.vc.wb_src = VREG_WB_SRC_MEMORY;
        m.multi     = 1'b1;
    end
    else if (w.opv.opcode == V_MAJOR_STORE_FP && w.opv.funct3 == V_MEM_WIDTH)
    begin
        m.ls    = 4'b1010;
        m.fixed = 1'b1;
    end
    else if (w.opv.opcode == V_MAJOR_OP_V && w.opv.funct3 == V_OPCFG)
    begin
        m.vc.csr_write   = 1'b1;
        m.vc.preserve_vl = (w.cfg.vs1 == 5'd0) && (w.cfg.vd == 5'd0);
        m.vc.set_vl_max  = (w.cfg.vs1 == 5'd0) && (w.cfg.vd != 5'd0);
    end
    else if (w.opv.opcode == V_MAJOR_OP_V)
    begin
        m.vc.vec_reg_write = 1'b1;
        m.multi            = 1'b1;
        case (w.opv.funct6)
            6'b000000: red = (w.opv.funct3 == V_OPMVV);
            6'b000010:
            begin
                m.pe.op = PE_ARITH_SUB;
                m.multi = 1'b0;
            end
            6'b000101: m.pe = pe_of(PE_ARITH_SUB, PE_SAT_NONE, PE_OP_MODE_PASS_MIN, vx, 2'b00);
            6'b000111:
            begin
                m.pe = pe_of(PE_ARITH_SUB, PE_SAT_NONE, PE_OP_MODE_PASS_MAX, vx, 2'b00);
                red  = (w.opv.funct3 == V_OPMVV);
            end
            6'b001001: m.pe.op = PE_ARITH_AND;
            6'b001010: m.pe.op = PE_ARITH_OR;
            6'b001011: m.pe.op = PE_ARITH_XOR;
            6'b010000:
            begin
                m.vc.vec_reg_write = 1'b0;
                m.vc.result_sel    = APU_RESULT_SRC_VS2_0;
                m.multi            = 1'b0;
            end
            6'b010111:
            begin
                m.vc.wb_src = VREG_WB_SRC_SCALAR;
                m.pe.operand = vxi;
            end
            6'b100001: m.pe.saturate = PE_SAT;
            6'b100101: m.pe = pe_of(PE_ARITH_LSHIFT, PE_SAT_NONE, PE_OP_MODE_RESULT, vxi, 2'b00);
            6'b100111: m.pe = pe_of(PE_ARITH_MUL, PE_SAT_UPPER, PE_OP_MODE_RESULT, vx, 2'b00);
            6'b101000:
                m.pe = pe_of(PE_ARITH_RSHIFT_LOG, PE_SAT_NONE, PE_OP_MODE_RESULT, vxi, 2'b00);
            6'b101001:
                m.pe = pe_of(PE_ARITH_RSHIFT_AR, PE_SAT_NONE, PE_OP_MODE_RESULT, vxi, 2'b00);
            6'b110001:
            begin
                m.pe.widening = 2'b01;
                red           = 1'b1;
            end
            6'b111011: m.pe = pe_of(PE_ARITH_MUL, PE_SAT_NONE, PE_OP_MODE_RESULT, vx, 2'b01);
            default:
            begin
                m.vc.vec_reg_write = 1'b0;
                m.multi            = 1'b0;
            end
        endcase
    end
    // reductions accumulate into one register
    if (red)
    begin
        m.pe.operand = PE_OPERAND_RIPPLE;
        m.fixed      = 1'b1;
        m.accum      = 1'b1;
    end
    return m;
endfunction

// one beat per four elements, vl of 0 counts as a full sixteen
function automatic int model_beats(logic multi, logic [4:0] vl);
    logic [4:0] vl_m1;
    vl_m1 = vl - 5'd1;
    return multi ? int'(vl_m1[3:2]) + 1 : 1;
endfunction

function automatic vreg_addr_t model_addr(instr_word_u w, logic fixed, int beat,
    logic [1:0] sew);
    vreg_addr_t a;
    logic [4:0] step;
    int         scale;
    scale = (sew == 2'd1) ? 2 : 1;
    step  = fixed ? 5'd0 : 5'(beat * scale);
    a.vs1 = w.opv.vs1 + step;
    a.vs2 = w.opv.vs2 + step;
    a.vd  = w.opv.vd + step;
    return a;
endfunction

function automatic int model_elems(model_ctrl_t m, logic last, logic [4:0] vl);
    if (!m.multi)
        return 0;
    if (last)
        return int'(vl[1:0]);
    return m.accum ? 1 : 0;
endfunction

function automatic int model_imm(instr_word_u w);
    return (w.opv.funct3 == V_OPCFG) ? int'(w.cfg.imm) : int'(w.opv.vs1);
endfunction

`endif

/* tb/tb_vector_decoder.sv */
// testbench of the vector decoder, random instructions checked cycle by cycle against a model
`timescale 1ns/1ps
`include "vdec_settings.svh"

module tb_vector_decoder;

    import vdec_pkg::*;

    `include "vdec_model.svh"

    typedef logic [`VDEC_IMM_W-1:0] count_t;

    localparam int max_cycles = 400 * 24;
    localparam logic [5:0] arith_f6 [16] = '{6'b000000, 6'b000010, 6'b000101, 6'b000111,
        6'b001001, 6'b001010, 6'b001011, 6'b010000, 6'b010111, 6'b100001, 6'b100101,
        6'b100111, 6'b101000, 6'b101001, 6'b110001, 6'b111011};
    localparam funct3_e arith_f3 [4] = '{V_OPIVV, V_OPIVI, V_OPIVX, V_OPMVV};

    logic                    clk;
    logic                    n_reset;
    logic                    apu_req_i;
    apu_req_t                apu_req_data_i;
    logic                    vlsu_ready_i;
    logic [`VDEC_VL_W-1:0]   vl_i;
    logic [`VDEC_SEW_W-1:0]  vsew_i;
    logic                    apu_gnt_o;
    logic                    apu_rvalid_o;
    logic                    core_halt_o;
    logic [`VDEC_XLEN-1:0]   scalar_a_o;
    logic [`VDEC_XLEN-1:0]   scalar_b_o;
    pe_ctrl_t                pe_ctrl_o;
    vec_ctrl_t               vec_ctrl_o;
    vlsu_ctrl_t              vlsu_ctrl_o;
    vreg_addr_t              vreg_addr_o;
    logic [1:0]              elements_to_write_o;
    logic [`VDEC_BEAT_W-1:0] beat_count_o;
    logic [`VDEC_IMM_W-1:0]  immediate_o;

    integer seed = 32'hd388;
    int     n_checks = 0;
    int     n_errors = 0;
    int     cycle_count = 0;

    vector_decoder_top u_vector_decoder_top (.*);

    always #5 clk = ~clk;

    // run limit sized for 400 instructions of up to 24 cycles
    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout after %0d cycles, the decoder stopped returning results", cycle_count);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_flag(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_scalar(input string name, input logic [`VDEC_XLEN-1:0] got,
        input logic [`VDEC_XLEN-1:0] exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_pe_ctrl(input pe_ctrl_t got, input pe_ctrl_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error pe_ctrl_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_vec_ctrl(input vec_ctrl_t got, input vec_ctrl_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error vec_ctrl_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_vlsu_ctrl(input vlsu_ctrl_t got, input vlsu_ctrl_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error vlsu_ctrl_o: got %h expected %h", got, exp);
        end
    endtask

    task automatic check_vreg_addr(input vreg_addr_t got, input vreg_addr_t exp);
        n_checks++;
        if (got !== exp)
        begin
            n_errors++;
            $display("error vreg_addr_o: got %h expected %h", got, exp);
        end
    endtask

    function automatic instr_word_u make_instr(logic [5:0] f6, funct3_e f3, major_opcode_e op);
        instr_word_u w;
        w            = instr_word_u'($random(seed));
        w.opv.funct6 = f6;
        w.opv.funct3 = f3;
        w.opv.opcode = op;
        return w;
    endfunction

    function automatic logic is_listed(logic [5:0] f6);
        foreach (arith_f6[i])
            if (arith_f6[i] == f6)
                return 1'b1;
        return 1'b0;
    endfunction

    // idle cycle checks, the decoder must be waiting
    task automatic check_idle();
        check_flag("apu_gnt_o", apu_gnt_o, 1'b1);
        check_flag("apu_rvalid_o", apu_rvalid_o, 1'b0);
        check_flag("core_halt_o", core_halt_o, 1'b0);
        check_vlsu_ctrl(vlsu_ctrl_o, '0);
        check_flag("vec_reg_write", vec_ctrl_o.vec_reg_write, 1'b0);
        check_flag("csr_write", vec_ctrl_o.csr_write, 1'b0);
        check_count("beat_count_o", count_t'(beat_count_o), '0);
    endtask

    // issue one instruction and follow it beat by beat until result valid
    task automatic run_instr(input instr_word_u w);
        model_ctrl_t m;
        logic [4:0]  vl;
        logic [1:0]  sew;
        logic [31:0] a;
        logic [31:0] b;
        int          beat;
        int          last;
        logic        adv;
        logic        done;
        m    = model_decode(w);
        vl   = 5'($random(seed));
        sew  = 2'($random(seed));
        a    = $random(seed);
        b    = $random(seed);
        last = model_beats(m.multi, vl) - 1;
        beat = 0;
        done = 1'b0;
        @(posedge clk);
        #1;
        apu_req_i      = 1'b1;
        apu_req_data_i = {w, a, b};
        vl_i           = vl;
        vsew_i         = sew;
        @(negedge clk);
        check_flag("apu_gnt_o", apu_gnt_o, 1'b1);
        check_flag("core_halt_o", core_halt_o, 1'b0);
        while (!done)
        begin
            @(posedge clk);
            #1;
            apu_req_i      = 1'b0;
            apu_req_data_i = {$random(seed), $random(seed), $random(seed)};
            // ready low about three cycles in ten
            vlsu_ready_i   = ({$random(seed)} % 10) >= 3;
            @(negedge clk);
            adv = !(m.ls.load || m.ls.store) || vlsu_ready_i;
            check_flag("core_halt_o", core_halt_o, 1'b1);
            check_flag("apu_gnt_o", apu_gnt_o, 1'b0);
            check_pe_ctrl(pe_ctrl_o, m.pe);
            check_vec_ctrl(vec_ctrl_o, m.vc);
            check_vlsu_ctrl(vlsu_ctrl_o, m.ls);
            check_vreg_addr(vreg_addr_o, model_addr(w, m.fixed, beat, sew));
            check_count("beat_count_o", count_t'(beat_count_o), count_t'(beat));
            check_count("elements_to_write_o", count_t'(elements_to_write_o),
                count_t'(model_elems(m, beat == last, vl)));
            check_count("immediate_o", immediate_o, count_t'(model_imm(w)));
            check_scalar("scalar_a_o", scalar_a_o, a);
            check_scalar("scalar_b_o", scalar_b_o, b);
            check_flag("apu_rvalid_o", apu_rvalid_o, adv && (beat == last));
            done = apu_rvalid_o;
            if (adv && beat < last)
                beat++;
        end
    endtask

    task automatic report_test(input string name, input int n_instr, input int errors_before);
        $display("test %s: %0d instructions, %0d errors", name, n_instr, n_errors - errors_before);
    endtask

    initial
    begin
        int          e0;
        logic [5:0]  f6;
        instr_word_u w;
        clk            = 1'b0;
        n_reset        = 1'b0;
        apu_req_i      = 1'b0;
        apu_req_data_i = '0;
        vlsu_ready_i   = 1'b1;
        vl_i           = 5'd4;
        vsew_i         = 2'd0;
        repeat (3) @(posedge clk);
        #1;
        n_reset = 1'b1;

        e0 = n_errors;
        @(negedge clk);
        check_idle();
        report_test("reset", 0, e0);

        e0 = n_errors;
        repeat (150)
            run_instr(make_instr(arith_f6[{$random(seed)} % 16], arith_f3[{$random(seed)} % 4],
                V_MAJOR_OP_V));
        report_test("arithmetic", 150, e0);

        // vredsum, vredmax, vwredsum
        e0 = n_errors;
        for (int i = 0; i < 40; i++)
        begin
            f6 = (i % 3 == 0) ? 6'b000000 : ((i % 3 == 1) ? 6'b000111 : 6'b110001);
            run_instr(make_instr(f6, V_OPMVV, V_MAJOR_OP_V));
        end
        report_test("reductions", 40, e0);

        e0 = n_errors;
        for (int i = 0; i < 30; i++)
        begin
            w = make_instr(6'($random(seed)), V_OPCFG, V_MAJOR_OP_V);
            if (i % 2 == 0)
                w.cfg.vs1 = 5'd0;
            if (i % 4 < 2)
                w.cfg.vd = 5'd0;
            run_instr(w);
        end
        report_test("vsetvli", 30, e0);

        e0 = n_errors;
        for (int i = 0; i < 120; i++)
        begin
            w = make_instr(6'($random(seed)), V_MEM_WIDTH,
                (i % 2 == 0) ? V_MAJOR_LOAD_FP : V_MAJOR_STORE_FP);
            if (i % 4 < 2)
                w.opv.funct6[2:0] = 3'd0;
            run_instr(w);
        end
        report_test("load/store", 120, e0);

        e0 = n_errors;
        for (int i = 0; i < 40; i++)
        begin
            f6 = 6'($random(seed));
            while (is_listed(f6))
                f6 = 6'($random(seed));
            run_instr(make_instr(f6, arith_f3[{$random(seed)} % 4], V_MAJOR_OP_V));
        end
        report_test("unsupported", 40, e0);

        @(posedge clk);
        #1;
        @(negedge clk);
        check_idle();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

/* verilog/apu_issue_ctrl.sv */
// APU issue control, grants one request at a time, holds it and paces its beats for the decoder
`timescale 1ns/1ps

module apu_issue_ctrl (
    input  logic                 clk,
    input  logic                 n_reset,
    input  logic                 apu_req_i,
    input  vdec_pkg::apu_req_t   apu_req_data_i,
    input  vdec_pkg::vlsu_ctrl_t vlsu_ctrl_i,
    input  logic                 vlsu_ready_i,
    input  logic                 last_beat_i,
    output vdec_pkg::apu_req_t   held_req_o,
    output logic                 exec_o,
    output logic                 beat_adv_o,
    output logic                 apu_gnt_o,
    output logic                 apu_rvalid_o,
    output logic                 core_halt_o
);

    import vdec_pkg::*;

    typedef enum logic {ST_WAIT, ST_EXEC} issue_state_e;

    issue_state_e state;
    issue_state_e state_next;
    logic         accept;
    logic         mem_op;

    assign accept = (state == ST_WAIT) && apu_req_i;

    // only memory beats wait on the load/store unit
    assign mem_op     = vlsu_ctrl_i.load | vlsu_ctrl_i.store;
    assign beat_adv_o = exec_o && (!mem_op || vlsu_ready_i);

    assign exec_o       = (state == ST_EXEC);
    assign apu_gnt_o    = (state == ST_WAIT);
    assign core_halt_o  = exec_o;
    assign apu_rvalid_o = beat_adv_o && last_beat_i;

    always_comb
    begin
        state_next = state;
        case (state)
            ST_WAIT:
                if (apu_req_i)
                    state_next = ST_EXEC;
            ST_EXEC:
                if (apu_rvalid_o)
                    state_next = ST_WAIT;
            default:
                state_next = ST_WAIT;
        endcase
    end

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
            state <= ST_WAIT;
        else
            state <= state_next;
    end

    // instruction word and scalars stay put for the whole instruction
    always_ff @(posedge clk)
    begin
        if (accept)
            held_req_o <= apu_req_data_i;
    end

endmodule

/* verilog/vdec_pkg.sv */
// types shared by the vector decoder RTL and testbench and compiled before every file that imports them
`include "vdec_settings.svh"

package vdec_pkg;

    typedef enum logic [6:0] {
        V_MAJOR_LOAD_FP  = 7'b0000111,
        V_MAJOR_STORE_FP = 7'b0100111,
        V_MAJOR_OP_V     = 7'b1010111
    } major_opcode_e;

    typedef enum logic [2:0] {
        V_OPIVV = 3'b000,
        V_OPMVV = 3'b010,
        V_OPIVI = 3'b011,
        V_OPIVX = 3'b100,
        V_OPCFG = 3'b111
    } funct3_e;

    // vector loads and stores carry this width code in the funct3 position
    localparam funct3_e V_MEM_WIDTH = V_OPCFG;

    // the first member of each control enum is its inactive value and encodes as zero
    typedef enum logic [3:0] {
        PE_ARITH_ADD,
        PE_ARITH_SUB,
        PE_ARITH_AND,
        PE_ARITH_OR,
        PE_ARITH_XOR,
        PE_ARITH_LSHIFT,
        PE_ARITH_RSHIFT_LOG,
        PE_ARITH_RSHIFT_AR,
        PE_ARITH_MUL
    } pe_arith_op_e;

    typedef enum logic [1:0] {PE_SAT_NONE, PE_SAT, PE_SAT_UPPER} pe_saturate_mode_e;

    typedef enum logic [1:0] {
        PE_OP_MODE_RESULT,
        PE_OP_MODE_PASS_MIN,
        PE_OP_MODE_PASS_MAX
    } pe_output_mode_e;

    typedef enum logic [1:0] {
        PE_OPERAND_VS1,
        PE_OPERAND_SCALAR,
        PE_OPERAND_IMMEDIATE,
        PE_OPERAND_RIPPLE
    } pe_operand_e;

    typedef enum logic [1:0] {
        VREG_WB_SRC_ARITH,
        VREG_WB_SRC_MEMORY,
        VREG_WB_SRC_SCALAR
    } vreg_wb_src_e;

    typedef enum logic {APU_RESULT_SRC_VL, APU_RESULT_SRC_VS2_0} apu_result_src_e;

    // arithmetic and memory format where funct6[2:0] is the addressing mode on memory ops
    typedef struct packed {
        logic [5:0]               funct6;
        // mask enable bit that the decoder ignores
        logic                     vm;
        logic [`VDEC_VREG_AW-1:0] vs2;
        logic [`VDEC_VREG_AW-1:0] vs1;
        funct3_e                  funct3;
        logic [`VDEC_VREG_AW-1:0] vd;
        major_opcode_e            opcode;
    } opv_fields_t;

    // vsetvli format
    typedef struct packed {
        logic                     spare;
        logic [`VDEC_IMM_W-1:0]   imm;
        logic [`VDEC_VREG_AW-1:0] vs1;
        funct3_e                  funct3;
        logic [`VDEC_VREG_AW-1:0] vd;
        major_opcode_e            opcode;
    } cfg_fields_t;

    typedef union packed {
        opv_fields_t opv;
        cfg_fields_t cfg;
    } instr_word_u;

    typedef struct packed {
        pe_arith_op_e      op;
        pe_saturate_mode_e saturate;
        pe_output_mode_e   out_mode;
        pe_operand_e       operand;
        logic [1:0]        widening;
    } pe_ctrl_t;

    typedef struct packed {
        logic            vec_reg_write;
        vreg_wb_src_e    wb_src;
        logic            csr_write;
        logic            preserve_vl;
        logic            set_vl_max;
        apu_result_src_e result_sel;
    } vec_ctrl_t;

    typedef struct packed {
        logic en;
        logic load;
        logic store;
        logic strided;
    } vlsu_ctrl_t;

    typedef struct packed {
        logic multi_beat;
        logic fix_addr;
        logic accumulate;
    } seq_ctrl_t;

    typedef struct packed {
        instr_word_u            instr;
        logic [`VDEC_XLEN-1:0] op_a;
        logic [`VDEC_XLEN-1:0] op_b;
    } apu_req_t;

    typedef struct packed {
        logic [`VDEC_VREG_AW-1:0] vs1;
        logic [`VDEC_VREG_AW-1:0] vs2;
        logic [`VDEC_VREG_AW-1:0] vd;
    } vreg_addr_t;

endpackage

/* verilog/vdec_settings.svh */
// width settings for the vector decoder, included by the package and the RTL that sizes ports
`ifndef VDEC_SETTINGS_SVH
`define VDEC_SETTINGS_SVH

// scalar operand width of the host core
`define VDEC_XLEN 32

// vector register file has 32 entries
`define VDEC_VREG_AW 5

// vector length, up to 16 elements
`define VDEC_VL_W 5

// up to four beats of four elements
`define VDEC_BEAT_W 2

// configuration immediate of vsetvli
`define VDEC_IMM_W 11

// element width selector, 0 is 8-bit and 1 is 16-bit
`define VDEC_SEW_W 2

`endif

/* verilog/vector_decoder_top.sv */
// vector decoder top level, sits on the core's APU port and drives the accelerator controls
`timescale 1ns/1ps
`include "vdec_settings.svh"

module vector_decoder_top (
    input  logic                    clk,
    input  logic                    n_reset,
    input  logic                    apu_req_i,
    input  vdec_pkg::apu_req_t      apu_req_data_i,
    input  logic                    vlsu_ready_i,
    input  logic [`VDEC_VL_W-1:0]   vl_i,
    input  logic [`VDEC_SEW_W-1:0]  vsew_i,
    output logic                    apu_gnt_o,
    output logic                    apu_rvalid_o,
    output logic                    core_halt_o,
    output logic [`VDEC_XLEN-1:0]   scalar_a_o,
    output logic [`VDEC_XLEN-1:0]   scalar_b_o,
    output vdec_pkg::pe_ctrl_t      pe_ctrl_o,
    output vdec_pkg::vec_ctrl_t     vec_ctrl_o,
    output vdec_pkg::vlsu_ctrl_t    vlsu_ctrl_o,
    output vdec_pkg::vreg_addr_t    vreg_addr_o,
    output logic [1:0]              elements_to_write_o,
    output logic [`VDEC_BEAT_W-1:0] beat_count_o,
    output logic [`VDEC_IMM_W-1:0]  immediate_o
);

    import vdec_pkg::*;

    apu_req_t  held_req;
    seq_ctrl_t seq_ctrl;
    logic      exec;
    logic      beat_adv;
    logic      last_beat;

    assign scalar_a_o = held_req.op_a;
    assign scalar_b_o = held_req.op_b;

    apu_issue_ctrl u_apu_issue_ctrl (
        .clk            (clk),
        .n_reset        (n_reset),
        .apu_req_i      (apu_req_i),
        .apu_req_data_i (apu_req_data_i),
        .vlsu_ctrl_i    (vlsu_ctrl_o),
        .vlsu_ready_i   (vlsu_ready_i),
        .last_beat_i    (last_beat),
        .held_req_o     (held_req),
        .exec_o         (exec),
        .beat_adv_o     (beat_adv),
        .apu_gnt_o      (apu_gnt_o),
        .apu_rvalid_o   (apu_rvalid_o),
        .core_halt_o    (core_halt_o)
    );

    vop_decode u_vop_decode (
        .instr_i     (held_req.instr),
        .exec_i      (exec),
        .pe_ctrl_o   (pe_ctrl_o),
        .vec_ctrl_o  (vec_ctrl_o),
        .vlsu_ctrl_o (vlsu_ctrl_o),
        .seq_ctrl_o  (seq_ctrl)
    );

    vreg_sequencer u_vreg_sequencer (
        .clk                 (clk),
        .n_reset             (n_reset),
        .exec_i              (exec),
        .beat_adv_i          (beat_adv),
        .seq_ctrl_i          (seq_ctrl),
        .instr_i             (held_req.instr),
        .vl_i                (vl_i),
        .vsew_i              (vsew_i),
        .last_beat_o         (last_beat),
        .beat_count_o        (beat_count_o),
        .vreg_addr_o         (vreg_addr_o),
        .elements_to_write_o (elements_to_write_o),
        .immediate_o         (immediate_o)
    );

endmodule

/* verilog/vop_decode.sv */
// vector instruction decode, turns the held instruction into per-beat control bundles
`timescale 1ns/1ps

module vop_decode (
    input  vdec_pkg::instr_word_u instr_i,
    input  logic                  exec_i,
    output vdec_pkg::pe_ctrl_t    pe_ctrl_o,
    output vdec_pkg::vec_ctrl_t   vec_ctrl_o,
    output vdec_pkg::vlsu_ctrl_t  vlsu_ctrl_o,
    output vdec_pkg::seq_ctrl_t   seq_ctrl_o
);

    import vdec_pkg::*;

    opv_fields_t opv;
    cfg_fields_t cfg;
    pe_operand_e opnd_vx;
    pe_operand_e opnd_vxi;
    logic        reduce;

    assign opv = instr_i.opv;
    assign cfg = instr_i.cfg;

    // operand for ops with .vv/.vx forms, and for those that also take .vi
    assign opnd_vx  = (opv.funct3 == V_OPIVX) ? PE_OPERAND_SCALAR : PE_OPERAND_VS1;
    assign opnd_vxi = (opv.funct3 == V_OPIVI) ? PE_OPERAND_IMMEDIATE : opnd_vx;

    always_comb
    begin
        // inert single-beat instruction with no writes
        pe_ctrl_o   = '0;
        vec_ctrl_o  = '0;
        vlsu_ctrl_o = '0;
        seq_ctrl_o  = '0;
        reduce      = 1'b0;

        if (exec_i)
        begin
            case (opv.opcode)
                V_MAJOR_LOAD_FP:
                    if (opv.funct3 == V_MEM_WIDTH)
                    begin
                        vec_ctrl_o.wb_src     = VREG_WB_SRC_MEMORY;
                        seq_ctrl_o.multi_beat = 1'b1;
                        vlsu_ctrl_o.en        = 1'b1;
                        vlsu_ctrl_o.load      = 1'b1;
                        vlsu_ctrl_o.strided   = |opv.funct6[2:0];
                    end
                V_MAJOR_STORE_FP:
                    if (opv.funct3 == V_MEM_WIDTH)
                    begin
                        seq_ctrl_o.fix_addr = 1'b1;
                        vlsu_ctrl_o.en      = 1'b1;
                        vlsu_ctrl_o.store   = 1'b1;
                    end
                V_MAJOR_OP_V:
                    if (opv.funct3 == V_OPCFG)
                    begin
                        // vsetvli, rs1 of x0 keeps vl or sets it to the maximum
                        vec_ctrl_o.csr_write = 1'b1;
                        if (cfg.vs1 == '0)
                        begin
                            vec_ctrl_o.preserve_vl = (cfg.vd == '0);
                            vec_ctrl_o.set_vl_max  = (cfg.vd != '0);
                        end
                    end
                    else
                    begin
                        // most ops write vd over several beats
                        vec_ctrl_o.vec_reg_write = 1'b1;
                        seq_ctrl_o.multi_beat    = 1'b1;
                        case (opv.funct6)
                            // vadd, vredsum
                            6'b000000:
                                reduce = (opv.funct3 == V_OPMVV);
                            // vsub is a single beat
                            6'b000010:
                            begin
                                pe_ctrl_o.op          = PE_ARITH_SUB;
                                seq_ctrl_o.multi_beat = 1'b0;
                            end
                            // vmin
                            6'b000101:
                            begin
                                pe_ctrl_o.op       = PE_ARITH_SUB;
                                pe_ctrl_o.out_mode = PE_OP_MODE_PASS_MIN;
                                pe_ctrl_o.operand  = opnd_vx;
                            end
                            // vmax, vredmax
                            6'b000111:
                            begin
                                pe_ctrl_o.op       = PE_ARITH_SUB;
                                pe_ctrl_o.out_mode = PE_OP_MODE_PASS_MAX;
                                pe_ctrl_o.operand  = opnd_vx;
                                reduce             = (opv.funct3 == V_OPMVV);
                            end
                            6'b001001:
                                pe_ctrl_o.op = PE_ARITH_AND;
                            6'b001010:
                                pe_ctrl_o.op = PE_ARITH_OR;
                            6'b001011:
                                pe_ctrl_o.op = PE_ARITH_XOR;
                            // vmv.x.s returns element 0 of vs2 to the core
                            6'b010000:
                            begin
                                vec_ctrl_o.vec_reg_write = 1'b0;
                                vec_ctrl_o.result_sel    = APU_RESULT_SRC_VS2_0;
                                seq_ctrl_o.multi_beat    = 1'b0;
                            end
                            // vmv.v
                            6'b010111:
                            begin
                                vec_ctrl_o.wb_src = VREG_WB_SRC_SCALAR;
                                pe_ctrl_o.operand = opnd_vxi;
                            end
                            // vsadd
                            6'b100001:
                                pe_ctrl_o.saturate = PE_SAT;
                            6'b100101:
                            begin
                                pe_ctrl_o.op      = PE_ARITH_LSHIFT;
                                pe_ctrl_o.operand = opnd_vxi;
                            end
                            // vsmul keeps the upper half
                            6'b100111:
                            begin
                                pe_ctrl_o.op       = PE_ARITH_MUL;
                                pe_ctrl_o.saturate = PE_SAT_UPPER;
                                pe_ctrl_o.operand  = opnd_vx;
                            end
                            6'b101000:
                            begin
                                pe_ctrl_o.op      = PE_ARITH_RSHIFT_LOG;
                                pe_ctrl_o.operand = opnd_vxi;
                            end
                            6'b101001:
                            begin
                                pe_ctrl_o.op      = PE_ARITH_RSHIFT_AR;
                                pe_ctrl_o.operand = opnd_vxi;
                            end
                            // vwredsum
                            6'b110001:
                            begin
                                pe_ctrl_o.widening = 2'b01;
                                reduce             = 1'b1;
                            end
                            // vwmul
                            6'b111011:
                            begin
                                pe_ctrl_o.op       = PE_ARITH_MUL;
                                pe_ctrl_o.widening = 2'b01;
                                pe_ctrl_o.operand  = opnd_vx;
                            end
                            default:
                            begin
                                vec_ctrl_o.vec_reg_write = 1'b0;
                                seq_ctrl_o.multi_beat    = 1'b0;
                            end
                        endcase
                    end
                default:
                    ;
            endcase
        end

        // reductions ripple through one accumulator register
        if (reduce)
        begin
            pe_ctrl_o.operand     = PE_OPERAND_RIPPLE;
            seq_ctrl_o.fix_addr   = 1'b1;
            seq_ctrl_o.accumulate = 1'b1;
        end
    end

endmodule

/* verilog/vreg_sequencer.sv */
// beat sequencer, counts beats and steps the vector register addresses for each group of four
`timescale 1ns/1ps
`include "vdec_settings.svh"

module vreg_sequencer (
    input  logic                       clk,
    input  logic                       n_reset,
    input  logic                       exec_i,
    input  logic                       beat_adv_i,
    input  vdec_pkg::seq_ctrl_t        seq_ctrl_i,
    input  vdec_pkg::instr_word_u      instr_i,
    input  logic [`VDEC_VL_W-1:0]      vl_i,
    input  logic [`VDEC_SEW_W-1:0]     vsew_i,
    output logic                       last_beat_o,
    output logic [`VDEC_BEAT_W-1:0]    beat_count_o,
    output vdec_pkg::vreg_addr_t       vreg_addr_o,
    output logic [1:0]                 elements_to_write_o,
    output logic [`VDEC_IMM_W-1:0]     immediate_o
);

    import vdec_pkg::*;

    logic [`VDEC_VL_W-1:0]    vl_m1;
    logic [`VDEC_BEAT_W-1:0]  last_idx;
    logic [`VDEC_VREG_AW-1:0] step;

    // four elements per beat, vl of 0 wraps round to a full four beats
    assign vl_m1       = vl_i - 1'b1;
    assign last_idx    = seq_ctrl_i.multi_beat ? vl_m1[`VDEC_BEAT_W+1:2] : '0;
    assign last_beat_o = (beat_count_o == last_idx);

    always_ff @(posedge clk or negedge n_reset)
    begin
        if (!n_reset)
            beat_count_o <= '0;
        else if (!exec_i || (beat_adv_i && last_beat_o))
            beat_count_o <= '0;
        else if (beat_adv_i)
            beat_count_o <= beat_count_o + 1'b1;
    end

    always_comb
    begin
        step = {{(`VDEC_VREG_AW-`VDEC_BEAT_W){1'b0}}, beat_count_o};
        // 16-bit elements fill registers twice as fast
        if (vsew_i == `VDEC_SEW_W'd1)
            step = step << 1;
        if (seq_ctrl_i.fix_addr)
            step = '0;

        vreg_addr_o.vs1 = instr_i.opv.vs1 + step;
        vreg_addr_o.vs2 = instr_i.opv.vs2 + step;
        vreg_addr_o.vd  = instr_i.opv.vd + step;
    end

    always_comb
    begin
        elements_to_write_o = 2'd0;
        if (seq_ctrl_i.multi_beat)
        begin
            // remainder on the final group, one partial sum on earlier ones
            if (last_beat_o)
                elements_to_write_o = vl_i[1:0];
            else if (seq_ctrl_i.accumulate)
                elements_to_write_o = 2'd1;
        end
    end

    assign immediate_o = (instr_i.opv.funct3 == V_OPCFG) ? instr_i.cfg.imm :
        {{(`VDEC_IMM_W-`VDEC_VREG_AW){1'b0}}, instr_i.opv.vs1};

endmodule
